/* source/uartPkg.sv */
package uartPkg;

    // serial frame format, 8N1
    localparam int DATA_BITS  = 8;
    localparam int OVERSAMPLE = 16;

    // 50 MHz * 2416 / 65536 gives about 1.8432 MHz
    // which is 16 ticks per bit at 115200 baud
    localparam int BAUD_ACC_WIDTH = 16;
    localparam int BAUD_INCREMENT = 2416;

    // AXI4-Lite bus widths
    localparam int AXI_ADDR_WIDTH = 4;
    localparam int AXI_DATA_WIDTH = 32;

    typedef logic [DATA_BITS-1:0]          byteT;
    typedef logic [$clog2(OVERSAMPLE)-1:0] tickCountT;
    typedef logic [$clog2(DATA_BITS)-1:0]  bitIndexT;

    typedef logic [AXI_ADDR_WIDTH-1:0] axiAddrT;
    typedef logic [AXI_DATA_WIDTH-1:0] axiDataT;
    typedef logic [1:0]                axiRespT;

    localparam axiRespT RESP_OKAY   = 2'b00;
    localparam axiRespT RESP_SLVERR = 2'b10;

    // register map
    localparam axiAddrT ADDR_TXDATA = 4'h0;
    localparam axiAddrT ADDR_RXDATA = 4'h4;
    localparam axiAddrT ADDR_STATUS = 4'h8;

    // status register bit positions
    localparam int STAT_TXBUSY   = 0;
    localparam int STAT_RXVALID  = 1;
    localparam int STAT_OVERRUN  = 2;
    localparam int STAT_FRAMEERR = 3;

    // literal prefixes keep the two state sets apart in one scope
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txStateT;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateT;

endpackage

/* source/uartCtrlIf.sv */
`timescale 1ns/1ps

interface uartCtrlIf import uartPkg::*; ();

    // transmit side
    logic txStart;
    byteT txData;
    logic txBusy;

    // receive side
    logic rxValid;
    byteT rxData;
    logic rxFrameErr;

    modport regs (
        output txStart,
        output txData,
        input  txBusy,
        input  rxValid,
        input  rxData,
        input  rxFrameErr
    );

    modport tx (
        input  txStart,
        input  txData,
        output txBusy
    );

    modport rx (
        output rxValid,
        output rxData,
        output rxFrameErr
    );

endinterface

/* source/baudTick.sv */
`timescale 1ns/1ps

module baudTick import uartPkg::*; (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [BAUD_ACC_WIDTH-1:0] acc;
    logic [BAUD_ACC_WIDTH:0]   accSum;

    // one extra bit holds the carry out
    assign accSum = {1'b0, acc} + (BAUD_ACC_WIDTH + 1)'(BAUD_INCREMENT);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc  <= '0;
            tick <= 1'b0;
        end else begin
            acc  <= accSum[BAUD_ACC_WIDTH-1:0];
            // carry marks one oversampling period
            tick <= accSum[BAUD_ACC_WIDTH];
        end
    end

endmodule

/* source/uartTx.sv */
`timescale 1ns/1ps

module uartTx import uartPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    uartCtrlIf.tx ctrl,
    output logic txd
);

    txStateT   state;
    tickCountT tickCnt;
    bitIndexT  bitIdx;
    byteT      txByte;

    assign ctrl.txBusy = (state != TX_IDLE);

    // frame payload, captured when a frame starts
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && ctrl.txStart) begin
            txByte <= ctrl.txData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            tickCnt <= '0;
            bitIdx  <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    txd <= 1'b1;
                    if (ctrl.txStart) begin
                        state   <= TX_START;
                        tickCnt <= '0;
                    end
                end
                TX_START: begin
                    if (tick) begin
                        if (txd) begin
                            // line drops on the first tick after the request
                            txd <= 1'b0;
                        end else if (tickCnt == tickCountT'(OVERSAMPLE - 1)) begin
                            tickCnt <= '0;
                            bitIdx  <= '0;
                            txd     <= txByte[0];
                            state   <= TX_DATA;
                        end else begin
                            tickCnt <= tickCnt + 1'b1;
                        end
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        if (tickCnt == tickCountT'(OVERSAMPLE - 1)) begin
                            tickCnt <= '0;
                            if (bitIdx == bitIndexT'(DATA_BITS - 1)) begin
                                txd   <= 1'b1;
                                state <= TX_STOP;
                            end else begin
                                // lsb first
                                bitIdx <= bitIdx + 1'b1;
                                txd    <= txByte[bitIdx + 1'b1];
                            end
                        end else begin
                            tickCnt <= tickCnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        if (tickCnt == tickCountT'(OVERSAMPLE - 1)) begin
                            tickCnt <= '0;
                            state   <= TX_IDLE;
                        end else begin
                            tickCnt <= tickCnt + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* source/uartRx.sv */
`timescale 1ns/1ps

module uartRx import uartPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic rxd,
    uartCtrlIf.rx ctrl
);

    logic      rxMeta;
    logic      rxSync;
    rxStateT   state;
    tickCountT tickCnt;
    bitIndexT  bitIdx;
    byteT      shiftReg;
    logic      bitEnd;

    // two-flop synchronizer, idles at the line's high level
    always_ff @(posedge clk) begin
        if (rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rxd;
            rxSync <= rxMeta;
        end
    end

    // sixteenth tick since the last sample point
    assign bitEnd = tick && (tickCnt == tickCountT'(OVERSAMPLE - 1));

    // data path, sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bitEnd) begin
            shiftReg[bitIdx] <= rxSync;
        end
        if (state == RX_STOP && bitEnd && rxSync) begin
            ctrl.rxData <= shiftReg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= RX_IDLE;
            tickCnt         <= '0;
            bitIdx          <= '0;
            ctrl.rxValid    <= 1'b0;
            ctrl.rxFrameErr <= 1'b0;
        end else begin
            ctrl.rxValid    <= 1'b0;
            ctrl.rxFrameErr <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rxSync) begin
                        state   <= RX_START;
                        tickCnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tickCnt == tickCountT'(OVERSAMPLE / 2 - 1)) begin
                            // half a bit in, a high line means it was a glitch
                            tickCnt <= '0;
                            bitIdx  <= '0;
                            state   <= rxSync ? RX_IDLE : RX_DATA;
                        end else begin
                            tickCnt <= tickCnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (bitEnd) begin
                        tickCnt <= '0;
                        if (bitIdx == bitIndexT'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bitEnd) begin
                        tickCnt <= '0;
                        state   <= RX_IDLE;
                        // stop bit must be high
                        if (rxSync) begin
                            ctrl.rxValid <= 1'b1;
                        end else begin
                            ctrl.rxFrameErr <= 1'b1;
                        end
                    end else if (tick) begin
                        tickCnt <= tickCnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* source/uartRegs.sv */
`timescale 1ns/1ps

module uartRegs import uartPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    awvalid,
    output logic    awready,
    input  axiAddrT awaddr,
    input  logic    wvalid,
    output logic    wready,
    input  axiDataT wdata,
    output logic    bvalid,
    input  logic    bready,
    output axiRespT bresp,
    input  logic    arvalid,
    output logic    arready,
    input  axiAddrT araddr,
    output logic    rvalid,
    input  logic    rready,
    output axiDataT rdata,
    output axiRespT rresp,
    uartCtrlIf.regs ctrl
);

    logic    awDone;
    logic    wDone;
    axiAddrT awAddrQ;
    axiDataT wDataQ;
    logic    awFire;
    logic    wFire;
    logic    arFire;
    logic    writeGo;
    axiAddrT writeAddr;
    axiDataT writeData;
    logic    txAccept;
    logic    readRxData;
    logic    readStatus;
    logic    rxHeld;
    byteT    rxByte;
    logic    overrun;
    logic    frameErr;
    axiDataT statusWord;

    // a pending response blocks new addresses on its path
    assign awready = !bvalid && !awDone;
    assign wready  = !bvalid && !wDone;
    assign arready = !rvalid;

    assign awFire = awvalid && awready;
    assign wFire  = wvalid && wready;
    assign arFire = arvalid && arready;

    // aw and w in any order, this cycle's beat or the held one
    assign writeAddr = awFire ? awaddr : awAddrQ;
    assign writeData = wFire ? wdata : wDataQ;
    assign writeGo   = (awDone || awFire) && (wDone || wFire);
    assign txAccept  = writeGo && (writeAddr == ADDR_TXDATA)
                     && !(ctrl.txBusy || ctrl.txStart);

    assign readRxData = arFire && (araddr == ADDR_RXDATA);
    assign readStatus = arFire && (araddr == ADDR_STATUS);

    always_comb begin
        statusWord                = '0;
        statusWord[STAT_TXBUSY]   = ctrl.txBusy;
        statusWord[STAT_RXVALID]  = rxHeld;
        statusWord[STAT_OVERRUN]  = overrun;
        statusWord[STAT_FRAMEERR] = frameErr;
    end

    // write channel control
    always_ff @(posedge clk) begin
        if (rst) begin
            awDone       <= 1'b0;
            wDone        <= 1'b0;
            bvalid       <= 1'b0;
            ctrl.txStart <= 1'b0;
        end else begin
            ctrl.txStart <= txAccept;
            if (writeGo) begin
                awDone <= 1'b0;
                wDone  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (awFire) awDone <= 1'b1;
                if (wFire) wDone <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) awAddrQ <= awaddr;
        if (wFire) wDataQ <= wdata;
        if (writeGo) bresp <= txAccept ? RESP_OKAY : RESP_SLVERR;
        if (txAccept) ctrl.txData <= writeData[DATA_BITS-1:0];
    end

    // read channel
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arFire) begin
            rresp <= RESP_OKAY;
            case (araddr)
                ADDR_RXDATA: rdata <= axiDataT'(rxByte);
                ADDR_STATUS: rdata <= statusWord;
                default: begin
                    rdata <= '0;
                    rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    // receive holding register and sticky flags
    always_ff @(posedge clk) begin
        if (ctrl.rxValid) rxByte <= ctrl.rxData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rxHeld   <= 1'b0;
            overrun  <= 1'b0;
            frameErr <= 1'b0;
        end else begin
            if (ctrl.rxValid) begin
                rxHeld <= 1'b1;
            end else if (readRxData) begin
                rxHeld <= 1'b0;
            end
            // new byte replaces one that nobody has read
            if (ctrl.rxValid && rxHeld && !readRxData) begin
                overrun <= 1'b1;
            end else if (readStatus) begin
                overrun <= 1'b0;
            end
            if (ctrl.rxFrameErr) begin
                frameErr <= 1'b1;
            end else if (readStatus) begin
                frameErr <= 1'b0;
            end
        end
    end

endmodule

/* source/uartTop.sv */
`timescale 1ns/1ps

module uartTop import uartPkg::*; (
    input  logic    clk,
    input  logic    rst,
    // AXI4-Lite slave
    input  logic    awvalid,
    output logic    awready,
    input  axiAddrT awaddr,
    input  logic    wvalid,
    output logic    wready,
    input  axiDataT wdata,
    output logic    bvalid,
    input  logic    bready,
    output axiRespT bresp,
    input  logic    arvalid,
    output logic    arready,
    input  axiAddrT araddr,
    output logic    rvalid,
    input  logic    rready,
    output axiDataT rdata,
    output axiRespT rresp,
    // serial line
    output logic    txd,
    input  logic    rxd
);

    logic tick;

    uartCtrlIf ctrl ();

    // shared 16x oversampling tick
    baudTick i_baud (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uartTx i_tx (
        .clk  (clk),
        .rst  (rst),
        .tick (tick),
        .ctrl (ctrl.tx),
        .txd  (txd)
    );

    uartRx i_rx (
        .clk  (clk),
        .rst  (rst),
        .tick (tick),
        .rxd  (rxd),
        .ctrl (ctrl.rx)
    );

    uartRegs i_regs (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .ctrl    (ctrl.regs)
    );

endmodule

/* tb/uartTop_assert.sv */
`timescale 1ns/1ps

module uartTopAssert import uartPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    bvalid,
    input logic    bready,
    input logic    rvalid,
    input logic    rready,
    input logic    txd,
    input txStateT txState,
    input logic    txStart,
    input logic    txBusy
);

    // responses stay up until the master takes them
    bHold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // idle line level
    txdIdle: assert property (@(posedge clk) disable iff (rst)
        txState == TX_IDLE |-> txd)
        else $error("txd low while the transmitter is idle");

    startNotBusy: assert property (@(posedge clk) disable iff (rst)
        !(txStart && txBusy))
        else $error("txStart raised while the transmitter is busy");

endmodule

bind uartTop uartTopAssert i_assert (
    .clk     (clk),
    .rst     (rst),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .txd     (txd),
    .txState (i_tx.state),
    .txStart (ctrl.txStart),
    .txBusy  (ctrl.txBusy)
);

/* tb/uartTb.sv */
`timescale 1ns/1ps

module uartTb import uartPkg::*; ();

    localparam real CLK_PERIOD      = 20.0;
    localparam int  RESET_CYCLES    = 16;
    localparam int  BIT_CYCLES      = 434;
    localparam int  FRAME_CYCLES    = 10 * BIT_CYCLES;
    localparam int  BUDGET_FRAMES   = 24;
    localparam real WATCHDOG_NS     = BUDGET_FRAMES * FRAME_CYCLES * CLK_PERIOD * 1.1;
    localparam int  POLL_LIMIT      = 3000;
    localparam int  LOOPBACK_BYTES  = 8;
    // low stop bit ends past the receiver's sample point but before its next start check
    localparam int  LOW_STOP_CYCLES = 320;
    localparam axiDataT MASK_TXBUSY  = axiDataT'(1) << STAT_TXBUSY;
    localparam axiDataT MASK_RXVALID = axiDataT'(1) << STAT_RXVALID;

    logic    clk;
    logic    rst;
    logic    awvalid;
    logic    awready;
    axiAddrT awaddr;
    logic    wvalid;
    logic    wready;
    axiDataT wdata;
    logic    bvalid;
    logic    bready;
    axiRespT bresp;
    logic    arvalid;
    logic    arready;
    axiAddrT araddr;
    logic    rvalid;
    logic    rready;
    axiDataT rdata;
    axiRespT rresp;
    logic    txd;
    logic    rxd;
    logic    useLoopback;
    logic    bangRxd;

    int          errorCount;
    int          checkCount;
    int          testCount;
    int          failedTests;
    int          testStartErrors;
    logic [31:0] lcgState;
    logic        modelRxValid;
    logic        modelOverrun;
    logic        modelFrameErr;

    // serial input comes from our own txd or from the bit-banger
    assign rxd = useLoopback ? txd : bangRxd;

    uartTop i_dut (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .txd     (txd),
        .rxd     (rxd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out at %0t before all tests finished", $time);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic nextByte(output byteT b);
        lcgState = lcgStep(lcgState);
        b = lcgState[23:16];
    endtask

    // status word as the register map defines it
    function automatic axiDataT expectedStatus(input logic busy, input logic held,
                                               input logic ovr, input logic ferr);
        axiDataT word;
        word                = '0;
        word[STAT_TXBUSY]   = busy;
        word[STAT_RXVALID]  = held;
        word[STAT_OVERRUN]  = ovr;
        word[STAT_FRAMEERR] = ferr;
        return word;
    endfunction

    task automatic checkByte(input string name, input byteT exp, input byteT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkData(input string name, input axiDataT exp, input axiDataT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkResp(input string name, input axiRespT exp, input axiRespT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkLevel(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("failure at %0t: %s", $time, what);
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount == testStartErrors) begin
            $display("test %0d %s: passed", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: failed, %0d errors", testCount, name,
                     errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // aw and w go out together, each drops after its own handshake
    task automatic axiWrite(input axiAddrT addr, input axiDataT data, output axiRespT resp);
        logic awHs;
        logic wHs;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b0;
        while (awvalid || wvalid) begin
            awHs = awvalid && awready;
            wHs  = wvalid && wready;
            @(negedge clk);
            if (awHs) awvalid = 1'b0;
            if (wHs) wvalid = 1'b0;
        end
        while (!bvalid) @(negedge clk);
        // bready held low one cycle so the slave has to hold its response
        @(negedge clk);
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input axiAddrT addr, output axiDataT data, output axiRespT resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b0;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        // rready held low one cycle so the slave has to hold its data
        @(negedge clk);
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic pollStatus(input axiDataT mask, input logic level, input string what);
        axiDataT word;
        axiRespT resp;
        int      polls;
        polls = 0;
        axiRead(ADDR_STATUS, word, resp);
        while ((((word & mask) != '0) !== level) && polls < POLL_LIMIT) begin
            polls++;
            axiRead(ADDR_STATUS, word, resp);
        end
        checkResp("rresp", RESP_OKAY, resp);
        if (((word & mask) != '0) !== level) begin
            reportFailure({what, " never showed up in the status register"});
        end
    endtask

    // start bit, eight data bits lsb first, then the stop bit
    task automatic sendFrame(input byteT data, input logic stopLevel);
        logic [9:0] frame;
        frame = {stopLevel, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            bangRxd = frame[0];
            frame   = frame >> 1;
            if (i == 9 && !stopLevel) begin
                waitCycles(LOW_STOP_CYCLES);
                bangRxd = 1'b1;
                waitCycles(BIT_CYCLES - LOW_STOP_CYCLES);
            end else begin
                waitCycles(BIT_CYCLES);
            end
        end
        bangRxd = 1'b1;
    endtask

    task automatic readStatusAndCheck();
        axiDataT word;
        axiRespT resp;
        axiRead(ADDR_STATUS, word, resp);
        checkResp("rresp", RESP_OKAY, resp);
        checkData("status", expectedStatus(1'b0, modelRxValid, modelOverrun, modelFrameErr),
                  word);
        // reading status clears the sticky flags
        modelOverrun  = 1'b0;
        modelFrameErr = 1'b0;
    endtask

    task automatic readRxAndCheck(input byteT exp);
        axiDataT word;
        axiRespT resp;
        axiRead(ADDR_RXDATA, word, resp);
        checkResp("rresp", RESP_OKAY, resp);
        checkByte("rxdata", exp, word[DATA_BITS-1:0]);
        checkData("rdata", axiDataT'(exp), word);
        modelRxValid = 1'b0;
    endtask

    task automatic testLoopback();
        byteT    b;
        axiRespT resp;
        for (int i = 0; i < LOOPBACK_BYTES; i++) begin
            nextByte(b);
            axiWrite(ADDR_TXDATA, axiDataT'(b), resp);
            checkResp("bresp", RESP_OKAY, resp);
            pollStatus(MASK_RXVALID, 1'b1, "received byte");
            modelRxValid = 1'b1;
            readRxAndCheck(b);
            pollStatus(MASK_TXBUSY, 1'b0, "transmitter idle");
        end
    endtask

    task automatic testBusyWrite();
        byteT    first;
        byteT    second;
        axiRespT resp;
        nextByte(first);
        nextByte(second);
        axiWrite(ADDR_TXDATA, axiDataT'(first), resp);
        checkResp("bresp", RESP_OKAY, resp);
        axiWrite(ADDR_TXDATA, axiDataT'(second), resp);
        checkResp("bresp", RESP_SLVERR, resp);
        pollStatus(MASK_RXVALID, 1'b1, "received byte");
        modelRxValid = 1'b1;
        readRxAndCheck(first);
        pollStatus(MASK_TXBUSY, 1'b0, "transmitter idle");
        // a second frame would have landed within this time
        waitCycles(FRAME_CYCLES);
        readStatusAndCheck();
    endtask

    task automatic testMapErrors();
        byteT    b;
        axiDataT word;
        axiRespT resp;
        axiRead(axiAddrT'(12), word, resp);
        checkData("rdata", '0, word);
        checkResp("rresp", RESP_SLVERR, resp);
        nextByte(b);
        sendFrame(b, 1'b1);
        modelRxValid = 1'b1;
        axiWrite(ADDR_RXDATA, 32'h0000_005a, resp);
        checkResp("bresp", RESP_SLVERR, resp);
        axiWrite(ADDR_STATUS, 32'h0000_000f, resp);
        checkResp("bresp", RESP_SLVERR, resp);
        readStatusAndCheck();
        readRxAndCheck(b);
        checkLevel("txd", 1'b1, txd);
    endtask

    initial begin
        byteT b1;
        byteT b2;
        awvalid         = 1'b0;
        awaddr          = '0;
        wvalid          = 1'b0;
        wdata           = '0;
        bready          = 1'b0;
        arvalid         = 1'b0;
        araddr          = '0;
        rready          = 1'b0;
        useLoopback     = 1'b1;
        bangRxd         = 1'b1;
        rst             = 1'b1;
        lcgState        = 32'd22023;
        errorCount      = 0;
        checkCount      = 0;
        testCount       = 0;
        failedTests     = 0;
        testStartErrors = 0;
        modelRxValid    = 1'b0;
        modelOverrun    = 1'b0;
        modelFrameErr   = 1'b0;
        waitCycles(RESET_CYCLES);
        rst = 1'b0;

        readStatusAndCheck();
        checkLevel("txd", 1'b1, txd);
        endTest("reset state");
        testLoopback();
        endTest("loopback");
        testBusyWrite();
        endTest("write while busy");

        useLoopback = 1'b0;
        nextByte(b1);
        nextByte(b2);
        sendFrame(b1, 1'b1);
        sendFrame(b2, 1'b1);
        modelRxValid = 1'b1;
        modelOverrun = 1'b1;
        readStatusAndCheck();
        readRxAndCheck(b2);
        readStatusAndCheck();
        endTest("overrun");

        nextByte(b1);
        sendFrame(b1, 1'b0);
        modelFrameErr = 1'b1;
        readStatusAndCheck();
        readStatusAndCheck();
        endTest("framing error");
        testMapErrors();
        endTest("map errors");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* compile.f */
source/uartPkg.sv
source/uartCtrlIf.sv
source/baudTick.sv
source/uartTx.sv
source/uartRx.sv
source/uartRegs.sv
source/uartTop.sv
tb/uartTop_assert.sv
tb/uartTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module uartTb

status=0
output=$(./obj_dir/VuartTb) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'NO ERRORS'; then
    exit 0
fi
echo "simulation failed"
exit 1
